// File: filelist.f
+incdir+src
src/rx_buffer_pkg.sv
src/rx_fifo.sv
src/rx_stats.sv
src/rx_apb_regs.sv
src/rx_buffer_top.sv
testbench/rx_buffer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the receive buffer testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  -f filelist.f --top-module rx_buffer_tb \
  --Mdir "$BUILD_DIR" -o rx_buffer_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/rx_buffer_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$LOG"; then
  echo "FAIL"
  exit 1
fi

echo "PASS"
exit 0

// File: src/rx_apb_regs.sv
//**********************************************************************
// APB register block
//**********************************************************************
`include "rx_buffer_consts.svh"

module rx_apb_regs (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  rx_buffer_pkg::apb_addr_t    paddr,
  input  logic [`RXB_APB_DW-1:0]      pwdata,
  output logic [`RXB_APB_DW-1:0]      prdata,
  output logic                        pready,
  output logic                        pslverr,
  input  rx_buffer_pkg::rx_word_t     head,
  input  rx_buffer_pkg::fifo_status_t status,
  input  rx_buffer_pkg::rx_stats_t    stats,
  output logic                        pop,
  output logic                        flush,
  output logic                        clear_stats
);

  import rx_buffer_pkg::*;

  localparam int PAD_W = `RXB_APB_DW - `RXB_STAT_W;

  apb_state_t state;
  apb_state_t state_nxt;

  logic [`RXB_APB_DW-1:0] rdata_nxt;
  logic                   err_nxt;
  logic                   pop_nxt;
  logic                   flush_nxt;
  logic                   clear_nxt;
  logic                   access;

  // First access cycle, decode is captured at its end
  assign access = (state == WAIT) && psel && penable;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (psel && !penable) state_nxt = WAIT;
      WAIT:    state_nxt = access ? DONE : IDLE;
      DONE:    state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  // Register map decode
  always_comb begin
    rdata_nxt = '0;
    err_nxt   = 1'b0;
    pop_nxt   = 1'b0;
    flush_nxt = 1'b0;
    clear_nxt = 1'b0;
    case (paddr)
      `RXB_ADDR_DATA: begin
        if (pwrite) begin
          err_nxt = 1'b1;
        end else if (!status.empty) begin
          rdata_nxt = {1'b1, 22'd0, head};
          pop_nxt   = 1'b1;
        end
      end
      `RXB_ADDR_STATUS: begin
        if (pwrite) err_nxt = 1'b1;
        else rdata_nxt = {22'd0, status.full, status.empty, 3'd0, status.count};
      end
      `RXB_ADDR_RX_CNT: begin
        if (pwrite) err_nxt = 1'b1;
        else rdata_nxt = {{PAD_W{1'b0}}, stats.rx_cnt};
      end
      `RXB_ADDR_DROP_CNT: begin
        if (pwrite) err_nxt = 1'b1;
        else rdata_nxt = {{PAD_W{1'b0}}, stats.drop_cnt};
      end
      `RXB_ADDR_MARK_CNT: begin
        if (pwrite) err_nxt = 1'b1;
        else rdata_nxt = {{PAD_W{1'b0}}, stats.mark_cnt};
      end
      `RXB_ADDR_CTRL: begin
        // Reads as zero
        if (pwrite) begin
          clear_nxt = pwdata[0];
          flush_nxt = pwdata[1];
        end
      end
      default: err_nxt = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= IDLE;
      prdata      <= '0;
      pslverr     <= 1'b0;
      pop         <= 1'b0;
      flush       <= 1'b0;
      clear_stats <= 1'b0;
    end else begin
      state <= state_nxt;
      if (access) begin
        prdata  <= rdata_nxt;
        pslverr <= err_nxt;
      end else if (state == DONE) begin
        pslverr <= 1'b0;
      end
      // Side effects pulse for the single pready cycle
      pop         <= access && pop_nxt;
      flush       <= access && flush_nxt;
      clear_stats <= access && clear_nxt;
    end
  end

  assign pready = (state == DONE);

  a_pready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    pready |=> !pready)
    else $error("pready held for more than one cycle");

  a_pready_psel: assert property (@(posedge clk) disable iff (!rst_n)
    pready |-> psel)
    else $error("pready raised outside a selected transfer");

endmodule

// File: src/rx_buffer_consts.svh
//**********************************************************************
// Receive buffer constants
//**********************************************************************
`ifndef RX_BUFFER_CONSTS_SVH
`define RX_BUFFER_CONSTS_SVH

// FIFO geometry
`define RXB_DEPTH         16
`define RXB_PTR_W         4
`define RXB_CNT_W         5

// Word, counter and bus widths
`define RXB_WORD_W        9
`define RXB_STAT_W        16
`define RXB_ADDR_W        8
`define RXB_APB_DW        32

// APB register offsets
`define RXB_ADDR_DATA     8'h00
`define RXB_ADDR_STATUS   8'h04
`define RXB_ADDR_RX_CNT   8'h08
`define RXB_ADDR_DROP_CNT 8'h0C
`define RXB_ADDR_MARK_CNT 8'h10
`define RXB_ADDR_CTRL     8'h14

`endif

// File: src/rx_buffer_pkg.sv
//**********************************************************************
// Receive buffer types
//**********************************************************************
`include "rx_buffer_consts.svh"

package rx_buffer_pkg;

  // Bit 8 is the mark for special characters
  typedef logic [`RXB_WORD_W-1:0] rx_word_t;
  typedef logic [`RXB_PTR_W-1:0]  fifo_ptr_t;
  typedef logic [`RXB_CNT_W-1:0]  fifo_cnt_t;
  typedef logic [`RXB_STAT_W-1:0] stat_cnt_t;
  typedef logic [`RXB_ADDR_W-1:0] apb_addr_t;

  // Incoming link beat, no back-pressure
  typedef struct packed {
    logic     valid;
    rx_word_t word;
  } rx_beat_t;

  typedef struct packed {
    fifo_cnt_t count;
    logic      empty;
    logic      full;
  } fifo_status_t;

  // Outcome of the beat in the current cycle
  typedef struct packed {
    logic accepted;
    logic dropped;
    logic marked;
  } fifo_event_t;

  typedef struct packed {
    stat_cnt_t rx_cnt;
    stat_cnt_t drop_cnt;
    stat_cnt_t mark_cnt;
  } rx_stats_t;

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    DONE
  } apb_state_t;

endpackage

// File: src/rx_buffer_top.sv
//**********************************************************************
// Receive buffer top level
//**********************************************************************
`include "rx_buffer_consts.svh"

module rx_buffer_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  rx_buffer_pkg::rx_beat_t  beat,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  rx_buffer_pkg::apb_addr_t paddr,
  input  logic [`RXB_APB_DW-1:0]   pwdata,
  output logic [`RXB_APB_DW-1:0]   prdata,
  output logic                     pready,
  output logic                     pslverr
);

  import rx_buffer_pkg::*;

  rx_word_t     fifo_head;
  fifo_status_t fifo_status;
  fifo_event_t  fifo_event;
  rx_stats_t    stats;
  logic         fifo_pop;
  logic         fifo_flush;
  logic         stats_clear;

  // Word storage, decides accept or drop
  rx_fifo i_rx_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .beat    (beat),
    .pop     (fifo_pop),
    .flush   (fifo_flush),
    .head    (fifo_head),
    .status  (fifo_status),
    .event_o (fifo_event)
  );

  rx_stats i_rx_stats (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_event (fifo_event),
    .clear      (stats_clear),
    .stats      (stats)
  );

  // Host side
  rx_apb_regs i_rx_apb_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .head        (fifo_head),
    .status      (fifo_status),
    .stats       (stats),
    .pop         (fifo_pop),
    .flush       (fifo_flush),
    .clear_stats (stats_clear)
  );

endmodule

// File: src/rx_fifo.sv
//**********************************************************************
// Receive word FIFO
//**********************************************************************
`include "rx_buffer_consts.svh"

module rx_fifo (
  input  logic                       clk,
  input  logic                       rst_n,
  input  rx_buffer_pkg::rx_beat_t    beat,
  input  logic                       pop,
  input  logic                       flush,
  output rx_buffer_pkg::rx_word_t    head,
  output rx_buffer_pkg::fifo_status_t status,
  output rx_buffer_pkg::fifo_event_t event_o
);

  import rx_buffer_pkg::*;

  rx_word_t  mem [`RXB_DEPTH];
  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  fifo_cnt_t count;

  logic empty;
  logic full;
  logic do_push;
  logic do_pop;

  assign empty = (count == '0);
  assign full  = (count == fifo_cnt_t'(`RXB_DEPTH));

  // Flush wins over both push and pop
  assign do_push = beat.valid && !full && !flush;
  assign do_pop  = pop && !empty && !flush;

  assign event_o.accepted = do_push;
  assign event_o.dropped  = beat.valid && !do_push;
  assign event_o.marked   = do_push && beat.word[8];

  assign head         = mem[rd_ptr];
  assign status.count = count;
  assign status.empty = empty;
  assign status.full  = full;

  // Storage array
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= beat.word;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Pointers advance by one per accepted operation
  a_wr_ptr_step: assert property (@(posedge clk) disable iff (!rst_n)
    !flush |=> wr_ptr == fifo_ptr_t'($past(wr_ptr) + $past(do_push)))
    else $error("write pointer did not follow push");

  a_rd_ptr_step: assert property (@(posedge clk) disable iff (!rst_n)
    !flush |=> rd_ptr == fifo_ptr_t'($past(rd_ptr) + $past(do_pop)))
    else $error("read pointer did not follow pop");

  // count' = count + push - pop
  a_occupancy: assert property (@(posedge clk) disable iff (!rst_n)
    !flush |=>
      count == fifo_cnt_t'($past(count) + $past(do_push) - $past(do_pop)))
    else $error("occupancy does not match push and pop");

  // The register block must never request a pop from an empty FIFO
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> !empty)
    else $error("pop requested while FIFO empty");

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count <= fifo_cnt_t'(`RXB_DEPTH))
    else $error("occupancy above depth");

  // A partially filled FIFO never has its pointers meet
  a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
    (do_push && !empty) |-> (wr_ptr != rd_ptr))
    else $error("write would overwrite unread data");

endmodule

// File: src/rx_stats.sv
//**********************************************************************
// Receive statistics counters
//**********************************************************************
module rx_stats (
  input  logic                       clk,
  input  logic                       rst_n,
  input  rx_buffer_pkg::fifo_event_t fifo_event,
  input  logic                       clear,
  output rx_buffer_pkg::rx_stats_t   stats
);

  import rx_buffer_pkg::*;

  rx_stats_t stats_q;

  // Increment that sticks at all ones
  function automatic stat_cnt_t sat_inc(stat_cnt_t cnt, logic inc);
    stat_cnt_t res;
    res = cnt;
    if (inc && (cnt != '1)) begin
      res = cnt + 1'b1;
    end
    return res;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stats_q <= '0;
    end else if (clear) begin
      // Events arriving with the clear are discarded
      stats_q <= '0;
    end else begin
      stats_q.rx_cnt   <= sat_inc(stats_q.rx_cnt, fifo_event.accepted);
      stats_q.drop_cnt <= sat_inc(stats_q.drop_cnt, fifo_event.dropped);
      stats_q.mark_cnt <= sat_inc(stats_q.mark_cnt, fifo_event.marked);
    end
  end

  assign stats = stats_q;

  // Counters only move up unless cleared
  a_no_decrease: assert property (@(posedge clk) disable iff (!rst_n)
    !clear |=> (stats_q.rx_cnt   >= $past(stats_q.rx_cnt))   &&
               (stats_q.drop_cnt >= $past(stats_q.drop_cnt)) &&
               (stats_q.mark_cnt >= $past(stats_q.mark_cnt)))
    else $error("statistics counter decreased without clear");

  // A marked word is always an accepted word
  a_mark_le_rx: assert property (@(posedge clk) disable iff (!rst_n)
    stats_q.mark_cnt <= stats_q.rx_cnt)
    else $error("mark count exceeds receive count");

endmodule

// File: testbench/rx_buffer_tb.sv
//**********************************************************************
// Receive buffer testbench
//**********************************************************************
`include "rx_buffer_consts.svh"

module rx_buffer_tb;

  import rx_buffer_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int N_RAND     = 10;
  localparam int N_FILL     = 20;
  localparam int N_STREAM   = 40;
  localparam int N_SREADS   = 24;
  // Beats plus transfers per test
  // Each beat or transfer takes at most 4 cycles
  localparam int N_OPS   = (N_RAND + 11) + (N_FILL + 5) + (`RXB_DEPTH + 2) +
                           (N_STREAM + N_SREADS + 1) + 11 + 14;
  localparam int TIMEOUT = (N_OPS * 4 + 100) * CLK_PERIOD;

  logic        clk = 1'b0;
  logic        rst_n;
  rx_beat_t    beat;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_addr_t   paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  // Reference model state
  rx_word_t    model_q[$];
  stat_cnt_t   m_rx = '0;
  stat_cnt_t   m_drop = '0;
  stat_cnt_t   m_mark = '0;
  logic        cap_req = 1'b0;
  logic        pop_due = 1'b0;
  logic        flush_due = 1'b0;
  logic        clear_due = 1'b0;
  logic [32:0] expected;

  logic [31:0] act_rdata;
  logic        act_err;
  event        xfer_done;
  logic [31:0] rd_data;
  logic        rd_err;
  logic [31:0] rnd;
  rx_word_t    word;
  logic [31:0] snap[4];
  integer      seed = 98;
  int          err_cnt = 0;
  int          fail_tests = 0;
  int          test_errs;

  always #(CLK_PERIOD / 2) clk = ~clk;

  rx_buffer_top i_rx_buffer_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .beat    (beat),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  // Expected {pslverr, prdata} from the register map and the model state
  function automatic logic [32:0] ref_read(apb_addr_t addr, logic wr);
    logic [31:0] data;
    logic        err;
    fifo_cnt_t   cnt;
    data = '0;
    err  = 1'b0;
    cnt  = fifo_cnt_t'(model_q.size());
    case (addr)
      `RXB_ADDR_DATA: begin
        if (cnt != '0) data = {1'b1, 22'd0, model_q[0]};
      end
      `RXB_ADDR_STATUS:   data = {22'd0, cnt == fifo_cnt_t'(`RXB_DEPTH), cnt == '0, 3'd0, cnt};
      `RXB_ADDR_RX_CNT:   data = {16'd0, m_rx};
      `RXB_ADDR_DROP_CNT: data = {16'd0, m_drop};
      `RXB_ADDR_MARK_CNT: data = {16'd0, m_mark};
      `RXB_ADDR_CTRL:     data = 32'd0;
      default:            err  = 1'b1;
    endcase
    // Only CTRL accepts writes and no write returns data
    if (wr) begin
      err  = (addr != `RXB_ADDR_CTRL);
      data = 32'd0;
    end
    return {err, data};
  endfunction

  function automatic stat_cnt_t sat_inc(stat_cnt_t c, logic inc);
    return (inc && c != '1) ? c + 1'b1 : c;
  endfunction

  // Model update at every edge
  // Transfer side effects land one edge after capture
  always @(posedge clk) begin : model_update
    logic take;
    logic do_flush;
    logic do_pop;
    logic do_clear;
    do_flush  = flush_due;
    do_pop    = pop_due;
    do_clear  = clear_due;
    flush_due = 1'b0;
    pop_due   = 1'b0;
    clear_due = 1'b0;
    if (cap_req) begin
      cap_req  = 1'b0;
      expected = ref_read(paddr, pwrite);
      pop_due  = !pwrite && paddr == `RXB_ADDR_DATA && model_q.size() > 0;
      if (pwrite && paddr == `RXB_ADDR_CTRL) begin
        flush_due = pwdata[1];
        clear_due = pwdata[0];
      end
    end
    take = beat.valid && model_q.size() < `RXB_DEPTH && !do_flush;
    if (do_flush) begin
      model_q.delete();
    end else begin
      if (do_pop) void'(model_q.pop_front());
      if (take) model_q.push_back(beat.word);
    end
    if (do_clear) begin
      m_rx   = '0;
      m_drop = '0;
      m_mark = '0;
    end else begin
      m_rx   = sat_inc(m_rx, take);
      m_drop = sat_inc(m_drop, beat.valid && !take);
      m_mark = sat_inc(m_mark, take && beat.word[8]);
    end
  end

  // Compare every completed transfer with the model
  always @(xfer_done) begin
    assert (act_rdata == expected[31:0] && act_err == expected[32]) else begin
      $display("ERR t=%0t addr %02h: expected %08h err %0b, got %08h err %0b",
               $time, paddr, expected[31:0], expected[32], act_rdata, act_err);
      err_cnt++;
    end
  end

  task automatic apb_xfer(input apb_addr_t addr, input logic wr, input logic [31:0] wdata,
                          output logic [31:0] data, output logic err);
    int acc_cycles;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable    = 1'b1;
    cap_req    = 1'b1;
    acc_cycles = 1;
    do begin
      @(posedge clk);
      #1;
      acc_cycles++;
    end while (!pready);
    // One wait state, pready in the second access cycle
    check_value("access cycles up to pready", 32'(acc_cycles), 32'd2);
    data      = prdata;
    err       = pslverr;
    act_rdata = prdata;
    act_err   = pslverr;
    -> xfer_done;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic send_beat(input logic valid, output rx_word_t sent);
    rnd        = $random(seed);
    sent       = rnd[8:0];
    beat.valid = valid;
    beat.word  = sent;
    @(posedge clk);
    #1;
    beat.valid = 1'b0;
  endtask

  task automatic check_value(input string what, input logic [31:0] act, input logic [31:0] exp);
    assert (act == exp) else begin
      $display("ERR t=%0t %s: expected %08h, got %08h", $time, what, exp, act);
      err_cnt++;
    end
  endtask

  // Store or compare STATUS and the three counters
  task automatic status_snapshot(input logic compare);
    for (int i = 0; i < 4; i++) begin
      apb_xfer(apb_addr_t'(`RXB_ADDR_STATUS + 4 * i), 1'b0, 32'd0, rd_data, rd_err);
      if (compare) check_value("register changed by error access", rd_data, snap[i]);
      else snap[i] = rd_data;
    end
  endtask

  task automatic end_test(input int num, input string name);
    if (err_cnt == test_errs) begin
      $display("Test %0d %s: pass", num, name);
    end else begin
      $display("Test %0d %s: FAIL with %0d errors", num, name, err_cnt - test_errs);
      fail_tests++;
    end
  endtask

  initial begin
    #(TIMEOUT);
    $display("Timeout: the tests did not finish within %0d time units", TIMEOUT);
    $display("Errors found");
    $finish;
  end

  initial begin
    rx_word_t sent_q[$];
    int       marks;
    rst_n   = 1'b0;
    beat    = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_errs = err_cnt;
    repeat (N_RAND) begin
      send_beat(1'b1, word);
      sent_q.push_back(word);
    end
    apb_xfer(`RXB_ADDR_STATUS, 1'b0, 32'd0, rd_data, rd_err);
    check_value("count after pushes", rd_data, 32'(N_RAND));
    repeat (N_RAND) begin
      apb_xfer(`RXB_ADDR_DATA, 1'b0, 32'd0, rd_data, rd_err);
      check_value("data word in order", rd_data, {1'b1, 22'd0, sent_q.pop_front()});
    end
    end_test(1, "ordering and marks");

    test_errs = err_cnt;
    apb_xfer(`RXB_ADDR_CTRL, 1'b1, 32'h1, rd_data, rd_err);
    marks = 0;
    for (int i = 0; i < N_FILL; i++) begin
      send_beat(1'b1, word);
      if (i < `RXB_DEPTH && word[8]) marks++;
    end
    apb_xfer(`RXB_ADDR_STATUS, 1'b0, 32'd0, rd_data, rd_err);
    check_value("status when full", rd_data, 32'h0000_0210);
    apb_xfer(`RXB_ADDR_DROP_CNT, 1'b0, 32'd0, rd_data, rd_err);
    check_value("drop count", rd_data, 32'(N_FILL - `RXB_DEPTH));
    apb_xfer(`RXB_ADDR_RX_CNT, 1'b0, 32'd0, rd_data, rd_err);
    check_value("receive count", rd_data, 32'(`RXB_DEPTH));
    apb_xfer(`RXB_ADDR_MARK_CNT, 1'b0, 32'd0, rd_data, rd_err);
    check_value("mark count", rd_data, 32'(marks));
    end_test(2, "full and drop");

    test_errs = err_cnt;
    repeat (`RXB_DEPTH) apb_xfer(`RXB_ADDR_DATA, 1'b0, 32'd0, rd_data, rd_err);
    apb_xfer(`RXB_ADDR_DATA, 1'b0, 32'd0, rd_data, rd_err);
    check_value("data read when empty", rd_data, 32'd0);
    apb_xfer(`RXB_ADDR_STATUS, 1'b0, 32'd0, rd_data, rd_err);
    check_value("status when empty", rd_data, 32'h0000_0100);
    end_test(3, "empty read");

    test_errs = err_cnt;
    fork
      repeat (N_STREAM) send_beat($random(seed) % 2 != 0, word);
      repeat (N_SREADS) apb_xfer(`RXB_ADDR_DATA, 1'b0, 32'd0, rd_data, rd_err);
    join
    apb_xfer(`RXB_ADDR_STATUS, 1'b0, 32'd0, rd_data, rd_err);
    end_test(4, "concurrent push and pop");

    test_errs = err_cnt;
    repeat (5) send_beat(1'b1, word);
    apb_xfer(`RXB_ADDR_CTRL, 1'b1, 32'h2, rd_data, rd_err);
    apb_xfer(`RXB_ADDR_STATUS, 1'b0, 32'd0, rd_data, rd_err);
    check_value("status after flush", rd_data, 32'h0000_0100);
    apb_xfer(`RXB_ADDR_CTRL, 1'b1, 32'h1, rd_data, rd_err);
    for (int i = 0; i < 3; i++) begin
      apb_xfer(apb_addr_t'(`RXB_ADDR_RX_CNT + 4 * i), 1'b0, 32'd0, rd_data, rd_err);
      check_value("counter after clear", rd_data, 32'd0);
    end
    end_test(5, "control");

    test_errs = err_cnt;
    repeat (3) send_beat(1'b1, word);
    status_snapshot(1'b0);
    apb_xfer(`RXB_ADDR_DATA, 1'b1, 32'h55, rd_data, rd_err);
    check_value("pslverr on DATA write", {31'd0, rd_err}, 32'd1);
    apb_xfer(`RXB_ADDR_STATUS, 1'b1, 32'h3, rd_data, rd_err);
    check_value("pslverr on STATUS write", {31'd0, rd_err}, 32'd1);
    apb_xfer(8'h40, 1'b0, 32'd0, rd_data, rd_err);
    check_value("pslverr on unmapped read", {31'd0, rd_err}, 32'd1);
    status_snapshot(1'b1);
    end_test(6, "error responses");

    $display("Tests run: 6, failed: %0d, checks failed: %0d", fail_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
